/* hdl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  // datapath and address width
  localparam int unsigned xlen = 32;

  // register index width and count
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned num_regs = 32;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

  // pc step per instruction, in bytes
  localparam logic [xlen-1:0] inst_len_bytes = 32'd4;

  // major opcodes, inst[6:0]
  // addi family
  localparam logic [6:0] op_imm = 7'b001_0011;
  localparam logic [6:0] op_lui = 7'b011_0111;
  localparam logic [6:0] op_auipc = 7'b001_0111;
  localparam logic [6:0] op_jal = 7'b110_1111;
  localparam logic [6:0] op_jalr = 7'b110_0111;
  // ecall / ebreak
  localparam logic [6:0] op_system = 7'b111_0011;

  // funct3 of addi inside op_imm
  localparam logic [2:0] funct3_addi = 3'b000;

  // what one instruction does, as seen by execute
  typedef enum logic [2:0] {
    // retire, no state change besides pc
    cls_nop = 3'd0,
    // rs1 + imm_i
    cls_addi = 3'd1,
    // imm_u only
    cls_lui = 3'd2,
    // pc + imm_u
    cls_auipc = 3'd3,
    // target pc + imm_j, link pc + 4
    cls_jal = 3'd4,
    // target rs1 + imm_i with bit 0 cleared, link pc + 4
    cls_jalr = 3'd5,
    // ebreak, core stops
    cls_halt = 3'd6
  } op_class_t;

endpackage

`default_nettype wire

/* hdl/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode
  import rv_core_pkg::*;
(
  input  wire logic [xlen-1:0]       inst,
  output op_class_t                  op_class,
  output logic      [xlen-1:0]       imm,
  output logic      [reg_addr_w-1:0] rs1_addr,
  output logic      [reg_addr_w-1:0] rs2_addr,
  output logic      [reg_addr_w-1:0] rd_addr,
  output logic                       rd_we
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic writes_rd;

  // fixed field positions, same for every format
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // register indices go straight to the register file
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd_addr = inst[11:7];

  // I format, sign bit is inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  // U format, upper 20 bits, low 12 zero
  assign imm_u = {inst[31:12], 12'h000};
  // J format, scrambled offset, always even
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // opcode/funct3 to class
  always_comb begin
    op_class = cls_nop;
    unique case (opcode)
      op_imm: begin
        // only addi is kept, other op-imm forms retire as nop
        if (funct3 == funct3_addi) begin
          op_class = cls_addi;
        end
      end
      op_lui: op_class = cls_lui;
      op_auipc: op_class = cls_auipc;
      op_jal: op_class = cls_jal;
      op_jalr: op_class = cls_jalr;
      op_system: begin
        // priv group (funct3 zero) stops the core, csr forms do nothing
        if (funct3 == 3'b000) begin
          op_class = cls_halt;
        end
      end
      default: op_class = cls_nop;
    endcase
  end

  // one immediate per class
  always_comb begin
    unique case (op_class)
      cls_addi, cls_jalr: imm = imm_i;
      cls_lui, cls_auipc: imm = imm_u;
      cls_jal: imm = imm_j;
      default: imm = '0;
    endcase
  end

  // classes that produce a register result
  always_comb begin
    unique case (op_class)
      cls_addi, cls_lui, cls_auipc, cls_jal, cls_jalr: writes_rd = 1'b1;
      default: writes_rd = 1'b0;
    endcase
  end

  // x0 is never a write target
  assign rd_we = writes_rd && (rd_addr != '0);

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import rv_core_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic [reg_addr_w-1:0] rs1_addr,
  output logic      [xlen-1:0]       rs1_data,
  input  wire logic                  wb_we,
  input  wire logic [reg_addr_w-1:0] wb_addr,
  input  wire logic [xlen-1:0]       wb_data
);

  // x0..x31, entry 0 unused as storage
  logic [xlen-1:0] regs [num_regs];

  // single write port, rising edge
  always_ff @(posedge clk) begin
    // entry 0 stays untouched even if the enable slips through
    if (wb_we && (wb_addr != '0)) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // combinational read, x0 reads as zero
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  // decoder masks rd = 0, so no enabled write should name x0
  assert property (@(posedge clk) wb_we |-> (wb_addr != '0))
    else $error("register write enabled to x0");

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import rv_core_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire op_class_t             op_class,
  input  wire logic [xlen-1:0]       imm,
  input  wire logic [xlen-1:0]       rs1_data,
  input  wire logic [reg_addr_w-1:0] rd_addr,
  input  wire logic                  rd_we,
  output logic      [xlen-1:0]       pc,
  output logic                       halted,
  output logic                       wb_we,
  output logic      [reg_addr_w-1:0] wb_addr,
  output logic      [xlen-1:0]       wb_data
);

  logic [xlen-1:0] add_a;
  logic [xlen-1:0] add_sum;
  logic [xlen-1:0] pc_seq;
  logic [xlen-1:0] next_pc;
  logic halting;

  // sequential successor, also the link address
  assign pc_seq = pc + inst_len_bytes;

  // pc-relative classes take pc, the rest rs1
  always_comb begin
    unique case (op_class)
      cls_auipc, cls_jal: add_a = pc;
      default: add_a = rs1_data;
    endcase
  end

  // the one shared adder: addi result, auipc result, jump target
  assign add_sum = add_a + imm;

  assign halting = (op_class == cls_halt);

  // next pc
  always_comb begin
    if (halted || halting) begin
      // park on the ebreak
      next_pc = pc;
    end else begin
      unique case (op_class)
        cls_jal: next_pc = add_sum;
        cls_jalr: next_pc = {add_sum[xlen-1:1], 1'b0};
        default: next_pc = pc_seq;
      endcase
    end
  end

  // pc and halt flag
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
      halted <= 1'b0;
    end else begin
      pc <= next_pc;
      if (halting) begin
        halted <= 1'b1;
      end
    end
  end

  // write-back source
  always_comb begin
    unique case (op_class)
      cls_jal, cls_jalr: wb_data = pc_seq;
      cls_lui: wb_data = imm;
      default: wb_data = add_sum;
    endcase
  end

  assign wb_addr = rd_addr;
  // nothing retires in reset or after the halt
  assign wb_we = rd_we && !halted && !rst;

  // jump targets must stay on word boundaries
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

/* hdl/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top
  import rv_core_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [xlen-1:0]       inst,
  output logic      [xlen-1:0]       pc,
  output logic                       halted,
  output logic                       commit_we,
  output logic      [reg_addr_w-1:0] commit_rd,
  output logic      [xlen-1:0]       commit_data
);

  // decoder to execute
  op_class_t op_class;
  logic [xlen-1:0] imm;
  logic [reg_addr_w-1:0] rd_addr;
  logic rd_we;

  // register read path
  logic [reg_addr_w-1:0] rs1_addr;
  logic [xlen-1:0] rs1_data;

  // decode the fetched word, same cycle
  instr_decode instr_decode_i (
    .inst     (inst),
    .op_class (op_class),
    .imm      (imm),
    .rs1_addr (rs1_addr),
    // rs2 has no consumer among the kept instructions
    .rs2_addr (),
    .rd_addr  (rd_addr),
    .rd_we    (rd_we)
  );

  // commit signals double as the register write port
  reg_file reg_file_i (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .wb_we    (commit_we),
    .wb_addr  (commit_rd),
    .wb_data  (commit_data)
  );

  // pc, adder, write-back, halt
  execute_stage execute_stage_i (
    .clk      (clk),
    .rst      (rst),
    .op_class (op_class),
    .imm      (imm),
    .rs1_data (rs1_data),
    .rd_addr  (rd_addr),
    .rd_we    (rd_we),
    .pc       (pc),
    .halted   (halted),
    .wb_we    (commit_we),
    .wb_addr  (commit_rd),
    .wb_data  (commit_data)
  );

endmodule

`default_nettype wire

/* testbench/rv_core_tb_enc.svh */
`ifndef RV_CORE_TB_ENC_SVH
`define RV_CORE_TB_ENC_SVH

// generic I format word, imm[11:0] rs1 funct3 rd opcode
function automatic logic [31:0] enc_i(input logic [6:0] opcode, input logic [2:0] funct3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
  return {imm, rs1, funct3, rd, opcode};
endfunction

function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
  return enc_i(op_imm, funct3_addi, rd, rs1, imm);
endfunction

function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
  return enc_i(op_jalr, 3'b000, rd, rs1, imm);
endfunction

// U format, imm20 lands in bits 31:12
function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm20);
  return {imm20, rd, op_lui};
endfunction

function automatic logic [31:0] enc_auipc(input logic [4:0] rd, input logic [19:0] imm20);
  return {imm20, rd, op_auipc};
endfunction

// J format, byte offset, bit 0 dropped
function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

// funct12 = 1, everything else zero
function automatic logic [31:0] enc_ebreak();
  return {12'h001, 5'd0, 3'b000, 5'd0, op_system};
endfunction

`endif

/* testbench/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb
  import rv_core_pkg::*;
();

  localparam int clk_period = 40;
  localparam int rom_depth = 256;
  // opcode 0 is unknown, retires as nop
  localparam logic [31:0] nop_word = 32'h0000_0000;

  logic clk = 1'b0;
  logic rst;
  logic [xlen-1:0] inst;
  logic [xlen-1:0] pc;
  logic halted;
  logic commit_we;
  logic [reg_addr_w-1:0] commit_rd;
  logic [xlen-1:0] commit_data;

  // program storage, one word per pc step
  logic [31:0] rom [rom_depth];
  logic [31:0] rom_idx;
  int prog_len = 0;
  bit prog_built = 1'b0;
  int seed;
  int error_count = 0;
  int cyc = 0;

  // reference model state
  logic [xlen-1:0] sh_regs [num_regs];
  logic [xlen-1:0] exp_pc;
  logic exp_halted;

  // model view of the current instruction
  logic [31:0] m_idx;
  logic [31:0] m_inst;
  logic [6:0] m_opc;
  logic [2:0] m_f3;
  logic [4:0] m_rd;
  logic [4:0] m_rs1;
  logic [xlen-1:0] m_rs1v;
  logic [xlen-1:0] m_imm_i;
  logic [xlen-1:0] m_imm_u;
  logic [xlen-1:0] m_imm_j;
  logic m_writes;
  logic m_we;
  logic [xlen-1:0] m_data;
  logic [xlen-1:0] m_next;
  logic m_halt;

  `include "rv_core_tb_enc.svh"

  rv_core_top rv_core_top_i (
    .clk         (clk),
    .rst         (rst),
    .inst        (inst),
    .pc          (pc),
    .halted      (halted),
    .commit_we   (commit_we),
    .commit_rd   (commit_rd),
    .commit_data (commit_data)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // combinational fetch from the dut pc
  assign rom_idx = (pc - reset_pc) >> 2;
  assign inst = (rom_idx < rom_depth) ? rom[rom_idx] : nop_word;

  // append one word to the program
  task automatic emit(input logic [31:0] word);
    rom[prog_len] = word;
    prog_len++;
  endtask

  task automatic build_program();
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] imm;
    int j0;
    int tgt;
    for (int i = 0; i < rom_depth; i++) begin
      rom[i] = nop_word;
    end
    // give every register a known value first
    for (int i = 1; i < num_regs; i++) begin
      emit(enc_addi(5'(i), 5'd0, 12'(i * 37 - 500)));
    end
    // random addi / lui / auipc, x0 allowed on both sides
    for (int n = 0; n < 48; n++) begin
      kind = $random(seed);
      rd = $random(seed);
      rs1 = $random(seed);
      imm = $random(seed);
      case (kind % 3)
        0: emit(enc_addi(rd[4:0], rs1[4:0], imm[11:0]));
        1: emit(enc_lui(rd[4:0], imm[31:12]));
        default: emit(enc_auipc(rd[4:0], imm[31:12]));
      endcase
    end
    j0 = prog_len;
    // jal skips one word
    emit(enc_jal(5'd1, 21'd8));
    emit(enc_addi(5'd5, 5'd0, 12'h7ff));
    // x6 = target - 4, plus an odd bit for jalr to clear
    tgt = j0 + 7;
    emit(enc_lui(5'd6, 20'h80000));
    emit(enc_addi(5'd6, 5'd6, 12'(tgt * 4 - 3)));
    emit(enc_jalr(5'd7, 5'd6, 12'd4));
    emit(enc_addi(5'd5, 5'd0, 12'd1));
    emit(enc_addi(5'd5, 5'd0, 12'd2));
    // landing point, write to x0, no commit
    emit(enc_addi(5'd0, 5'd9, 12'd5));
    // x0 read after that write gives the immediate alone
    emit(enc_addi(5'd8, 5'd0, 12'h923));
    // xori, not kept
    emit(enc_i(op_imm, 3'b100, 5'd10, 5'd1, 12'h055));
    // custom-0 opcode, rd = x31
    emit(32'h0000_0f8b);
    emit(enc_ebreak());
    prog_built = 1'b1;
  endtask

  // expected effect of the word at exp_pc
  always_comb begin
    m_idx = (exp_pc - reset_pc) >> 2;
    m_inst = (m_idx < rom_depth) ? rom[m_idx] : nop_word;
    m_opc = m_inst[6:0];
    m_f3 = m_inst[14:12];
    m_rd = m_inst[11:7];
    m_rs1 = m_inst[19:15];
    m_rs1v = sh_regs[m_rs1];
    m_imm_i = {{20{m_inst[31]}}, m_inst[31:20]};
    m_imm_u = {m_inst[31:12], 12'h000};
    m_imm_j = {{12{m_inst[31]}}, m_inst[19:12], m_inst[20], m_inst[30:21], 1'b0};
    m_writes = 1'b0;
    m_data = '0;
    m_next = exp_pc + 32'd4;
    m_halt = 1'b0;
    case (m_opc)
      op_imm: begin
        if (m_f3 == funct3_addi) begin
          m_writes = 1'b1;
          m_data = m_rs1v + m_imm_i;
        end
      end
      op_lui: begin
        m_writes = 1'b1;
        m_data = m_imm_u;
      end
      op_auipc: begin
        m_writes = 1'b1;
        m_data = exp_pc + m_imm_u;
      end
      op_jal: begin
        m_writes = 1'b1;
        m_data = exp_pc + 32'd4;
        m_next = exp_pc + m_imm_j;
      end
      op_jalr: begin
        m_writes = 1'b1;
        m_data = exp_pc + 32'd4;
        m_next = (m_rs1v + m_imm_i) & ~32'd1;
      end
      op_system: begin
        if (m_f3 == 3'b000) begin
          m_halt = 1'b1;
        end
      end
      default: ;
    endcase
    // halted or halting core holds pc
    if (exp_halted || m_halt) begin
      m_next = exp_pc;
    end
    m_we = m_writes && (m_rd != 5'd0) && !exp_halted;
  end

  // model advance, x0 stays zero
  always @(posedge clk) begin
    if (rst) begin
      exp_pc <= reset_pc;
      exp_halted <= 1'b0;
      sh_regs[0] <= '0;
    end else begin
      if (m_we) begin
        sh_regs[m_rd] <= m_data;
      end
      exp_pc <= m_next;
      if (m_halt) begin
        exp_halted <= 1'b1;
      end
    end
  end

  // reset state, from the second reset edge on
  assert property (@(posedge clk) (rst && cyc > 0) |-> (pc == reset_pc && !halted && !commit_we))
    else begin
      error_count++;
      $display("[FAIL] %0t reset state pc expected %h actual %h, halted %b commit_we %b",
               $time, reset_pc, $sampled(pc), $sampled(halted), $sampled(commit_we));
    end

  assert property (@(posedge clk) disable iff (rst) pc == exp_pc)
    else begin
      error_count++;
      $display("[FAIL] %0t pc expected %h actual %h", $time, $sampled(exp_pc), $sampled(pc));
    end

  assert property (@(posedge clk) disable iff (rst) halted == exp_halted)
    else begin
      error_count++;
      $display("[FAIL] %0t halted expected %b actual %b",
               $time, $sampled(exp_halted), $sampled(halted));
    end

  assert property (@(posedge clk) disable iff (rst) commit_we == m_we)
    else begin
      error_count++;
      $display("[FAIL] %0t commit_we expected %b actual %b",
               $time, $sampled(m_we), $sampled(commit_we));
    end

  assert property (@(posedge clk) disable iff (rst) commit_rd == m_rd)
    else begin
      error_count++;
      $display("[FAIL] %0t commit_rd expected %0d actual %0d",
               $time, $sampled(m_rd), $sampled(commit_rd));
    end

  // data only matters on a real write
  assert property (@(posedge clk) disable iff (rst) m_we |-> commit_data == m_data)
    else begin
      error_count++;
      $display("[FAIL] %0t commit_data expected %h actual %h",
               $time, $sampled(m_data), $sampled(commit_data));
    end

  initial begin : stimulus
    rst = 1'b1;
    seed = 32'h409dc4dc;
    build_program();
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    // run until the core parks on ebreak
    do begin
      @(posedge clk);
      #1;
    end while (!halted);
    // a few more edges to see the frozen state
    repeat (6) @(posedge clk);
    #1;
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // program length plus margin for reset and the halted tail
  initial begin : watchdog
    wait (prog_built);
    #((prog_len + 20) * clk_period);
    $display("timeout: core did not halt within %0d cycles", prog_len + 20);
    $display("errors: %0d", error_count);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core.f */
+incdir+testbench
hdl/rv_core_pkg.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/rv_core_top.sv
testbench/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - hdl/rv_core_pkg.sv
      - hdl/instr_decode.sv
      - hdl/reg_file.sv
      - hdl/execute_stage.sv
      - hdl/rv_core_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/rv_core_tb.sv
